//--- Makefile
# Verilator build and run of the fetch path testbench

sim:
	verilator --binary --timing --assert -f project.f --top-module fetch_tb -o Vfetch_tb
	./obj_dir/Vfetch_tb > sim.log 2>&1
	cat sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- project.f
source/cache_pkg.sv
source/fetch_pkg.sv
source/icache.sv
source/fetch_pc_gen.sv
source/fetch_control.sv
source/fetch_top.sv
tests/fetch_tb.sv

//--- source/cache_pkg.sv
package cache_pkg;

	// Address and data share one width
	localparam int ADDR_W = 32;

	// Byte offset within a line of four words
	localparam int OFFSET_W = 4;

	localparam int INDEX_W = 2;

	localparam int TAG_W = ADDR_W - OFFSET_W - INDEX_W;

	localparam int WORDS_PER_LINE = 2 ** (OFFSET_W - 2);

	localparam int NUM_SETS = 2 ** INDEX_W;

endpackage

//--- source/fetch_control.sv
`timescale 1ns/1ps

module fetch_control (
	input  logic                         clock,
	input  logic                         reset,
	input  logic [cache_pkg::ADDR_W-1:0] pc,

	input  logic                         resp_valid,
	input  logic                         resp_hit,
	input  logic [cache_pkg::ADDR_W-1:0] resp_data,

	input  logic                         redirect,
	input  logic                         inst_ready,

	input  logic                         mem_rvalid,
	input  logic [cache_pkg::ADDR_W-1:0] mem_rdata,

	output logic                         issue,
	output logic                         advance,
	output logic                         fence_i,

	output logic [cache_pkg::ADDR_W-1:0] fill_addr,
	output logic [cache_pkg::ADDR_W-1:0] fill_data,
	output logic                         fill_valid,

	output logic                         mem_req,
	output logic [cache_pkg::ADDR_W-1:0] mem_addr,

	output logic [cache_pkg::ADDR_W-1:0] inst,
	output logic [cache_pkg::ADDR_W-1:0] inst_pc,
	output logic                         inst_valid
);
	import cache_pkg::*;
	import fetch_pkg::*;

	fetch_state_t        state;
	fetch_state_t        state_next;
	logic [OFFSET_W-3:0] word_count;
	logic [ADDR_W-1:0]   line_base;
	logic                redirect_pending;
	logic                transfer;
	logic                last_word;
	logic                drop_resp;
	inst_opcode_t        opcode;

	assign transfer  = (state == hold) && inst_ready;
	assign last_word = (word_count == (OFFSET_W - 2)'(WORDS_PER_LINE - 1));
	// A response fetched before a redirect is stale
	assign drop_resp = redirect || redirect_pending;

	always_comb begin
		state_next = state;
		issue      = 1'b0;
		case (state)
			idle: begin
				issue      = 1'b1;
				state_next = wait_resp;
			end
			wait_resp: begin
				if (resp_valid) begin
					if (drop_resp) begin
						issue = 1'b1;
					end else if (resp_hit) begin
						state_next = hold;
					end else begin
						state_next = refill_req;
					end
				end
			end
			refill_req: begin
				state_next = refill_wait;
			end
			refill_wait: begin
				// Refill always completes before pc is fetched again
				if (mem_rvalid) begin
					if (last_word) begin
						issue      = 1'b1;
						state_next = wait_resp;
					end else begin
						state_next = refill_req;
					end
				end
			end
			hold: begin
				if (inst_ready || redirect) begin
					issue      = 1'b1;
					state_next = wait_resp;
				end
			end
			default: begin
				state_next = idle;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state            <= idle;
			word_count       <= '0;
			redirect_pending <= 1'b0;
		end else begin
			state <= state_next;
			if (issue) begin
				redirect_pending <= 1'b0;
			end else if (redirect) begin
				redirect_pending <= 1'b1;
			end
			// Wraps back to zero after the last word of the line
			if (fill_valid) begin
				word_count <= word_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (state == wait_resp && resp_valid) begin
			inst      <= resp_data;
			inst_pc   <= pc;
			line_base <= {pc[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
		end
	end

	assign opcode  = inst_opcode_t'(inst[6:0]);
	assign advance = transfer;
	assign fence_i = transfer && (opcode == op_misc_mem) && (inst[14:12] == FUNCT3_FENCE_I);

	assign mem_req    = (state == refill_req);
	assign mem_addr   = line_base + ADDR_W'({word_count, 2'b00});
	assign fill_valid = (state == refill_wait) && mem_rvalid;
	assign fill_addr  = mem_addr;
	assign fill_data  = mem_rdata;
	assign inst_valid = (state == hold);

	// First word of a line follows a miss, each later word follows the previous return
	mem_req_after_miss: assert property (
		@(posedge clock) disable iff (reset)
		mem_req |-> ((word_count == '0) ? $past(resp_valid && !resp_hit)
			: $past(mem_rvalid))
	) else $error("fetch_control: mem_req without a miss or a returned word");

	held_inst_stable: assert property (
		@(posedge clock) disable iff (reset)
		inst_valid && !inst_ready && !redirect |=>
			inst_valid && $stable(inst) && $stable(inst_pc)
	) else $error("fetch_control: held instruction changed under back-pressure");

endmodule

//--- source/fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         issue,
	input  logic                         advance,
	input  logic                         redirect,
	input  logic [cache_pkg::ADDR_W-1:0] redirect_pc,
	output logic [cache_pkg::ADDR_W-1:0] pc,
	output logic                         fetch_valid
);
	import cache_pkg::*;
	import fetch_pkg::*;

	// Redirect wins over advance, so an issue in the same cycle
	// fetches from the new address
	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= RESET_PC;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (advance) begin
			pc <= pc + ADDR_W'(4);
		end
	end

	// Registered together with pc so the cache sees the updated address
	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= issue;
		end
	end

endmodule

//--- source/fetch_pkg.sv
package fetch_pkg;

	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	// funct3 that marks fence.i inside the misc_mem opcode
	localparam logic [2:0] FUNCT3_FENCE_I = 3'b001;

	typedef enum logic [2:0] {
		idle,
		wait_resp,
		refill_req,
		refill_wait,
		hold
	} fetch_state_t;

	// Only misc_mem matters to fetch, everything else falls in op_other
	typedef enum logic [6:0] {
		op_misc_mem = 7'b0001111,
		op_other    = 7'b1111111
	} inst_opcode_t;

endpackage

//--- source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
	input  logic                         clock,
	input  logic                         reset,

	input  logic                         redirect,
	input  logic [cache_pkg::ADDR_W-1:0] redirect_pc,

	output logic [cache_pkg::ADDR_W-1:0] inst,
	output logic [cache_pkg::ADDR_W-1:0] inst_pc,
	output logic                         inst_valid,
	input  logic                         inst_ready,

	output logic                         mem_req,
	output logic [cache_pkg::ADDR_W-1:0] mem_addr,
	input  logic                         mem_rvalid,
	input  logic [cache_pkg::ADDR_W-1:0] mem_rdata
);
	import cache_pkg::*;

	logic [ADDR_W-1:0] pc;
	logic              fetch_valid;
	logic              issue;
	logic              advance;
	logic              fence_i;
	logic [ADDR_W-1:0] resp_data;
	logic              resp_hit;
	logic              resp_valid;
	logic [ADDR_W-1:0] fill_addr;
	logic [ADDR_W-1:0] fill_data;
	logic              fill_valid;

	fetch_pc_gen pc_gen (
		.clock       (clock),
		.reset       (reset),
		.issue       (issue),
		.advance     (advance),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.pc          (pc),
		.fetch_valid (fetch_valid)
	);

	icache cache (
		.clock       (clock),
		.reset       (reset),
		.fetch_addr  (pc),
		.fetch_valid (fetch_valid),
		.resp_data   (resp_data),
		.resp_hit    (resp_hit),
		.resp_valid  (resp_valid),
		.fill_addr   (fill_addr),
		.fill_data   (fill_data),
		.fill_valid  (fill_valid),
		.fence_i     (fence_i)
	);

	fetch_control control (
		.clock       (clock),
		.reset       (reset),
		.pc          (pc),
		.resp_valid  (resp_valid),
		.resp_hit    (resp_hit),
		.resp_data   (resp_data),
		.redirect    (redirect),
		.inst_ready  (inst_ready),
		.mem_rvalid  (mem_rvalid),
		.mem_rdata   (mem_rdata),
		.issue       (issue),
		.advance     (advance),
		.fence_i     (fence_i),
		.fill_addr   (fill_addr),
		.fill_data   (fill_data),
		.fill_valid  (fill_valid),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.inst        (inst),
		.inst_pc     (inst_pc),
		.inst_valid  (inst_valid)
	);

endmodule

//--- source/icache.sv
`timescale 1ns/1ps

module icache (
	input  logic                         clock,
	input  logic                         reset,

	input  logic [cache_pkg::ADDR_W-1:0] fetch_addr,
	input  logic                         fetch_valid,

	output logic [cache_pkg::ADDR_W-1:0] resp_data,
	output logic                         resp_hit,
	output logic                         resp_valid,

	input  logic [cache_pkg::ADDR_W-1:0] fill_addr,
	input  logic [cache_pkg::ADDR_W-1:0] fill_data,
	input  logic                         fill_valid,

	input  logic                         fence_i
);
	import cache_pkg::*;

	logic [ADDR_W-1:0]   data_mem [NUM_SETS][WORDS_PER_LINE];
	logic [TAG_W-1:0]    tag_mem  [NUM_SETS];
	logic [NUM_SETS-1:0] valid_bits;

	logic [TAG_W-1:0]    read_tag;
	logic [INDEX_W-1:0]  read_index;
	logic [OFFSET_W-3:0] read_offset;
	logic [TAG_W-1:0]    write_tag;
	logic [INDEX_W-1:0]  write_index;
	logic [OFFSET_W-3:0] write_offset;
	logic                lookup_hit;

	// Address split: tag | index | word offset | byte offset
	assign read_tag     = fetch_addr[ADDR_W-1:OFFSET_W+INDEX_W];
	assign read_index   = fetch_addr[OFFSET_W+INDEX_W-1:OFFSET_W];
	assign read_offset  = fetch_addr[OFFSET_W-1:2];
	assign write_tag    = fill_addr[ADDR_W-1:OFFSET_W+INDEX_W];
	assign write_index  = fill_addr[OFFSET_W+INDEX_W-1:OFFSET_W];
	assign write_offset = fill_addr[OFFSET_W-1:2];

	assign lookup_hit = valid_bits[read_index] && (tag_mem[read_index] == read_tag);

	always_ff @(posedge clock) begin
		if (fetch_valid) begin
			resp_data <= data_mem[read_index][read_offset];
			resp_hit  <= lookup_hit;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= fetch_valid;
		end
	end

	// fence.i drops every line at once
	always_ff @(posedge clock) begin
		if (reset || fence_i) begin
			valid_bits <= '0;
		end else if (fill_valid) begin
			valid_bits[write_index] <= 1'b1;
		end
	end

	// Each refill word rewrites the tag of its set
	always_ff @(posedge clock) begin
		if (fill_valid) begin
			data_mem[write_index][write_offset] <= fill_data;
			tag_mem[write_index]                <= write_tag;
		end
	end

	// Lookup and refill share no port, the controller keeps them apart
	fetch_fill_exclusive: assert property (
		@(posedge clock) disable iff (reset) !(fetch_valid && fill_valid)
	) else $error("icache: fetch_valid and fill_valid high together");

endmodule

//--- tests/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
	import cache_pkg::*;

	localparam logic [31:0] START_PC    = 32'h0000_0000;
	localparam logic [31:0] FENCE_PC    = 32'h0000_0028;
	localparam logic [31:0] FENCE_WORD  = 32'h0000_100f;
	localparam logic [31:0] WORD_OFFSET = 32'h5a00_0000;
	localparam int PLANNED_FETCHES    = 32;
	// Four words at the longest memory delay, plus issue and lookup
	localparam int WORST_FETCH_CYCLES = 4 * (4 + 3) + 8;
	localparam int TIMEOUT_NS         = PLANNED_FETCHES * WORST_FETCH_CYCLES * 8 * 4;

	logic              clock;
	logic              reset;
	logic              redirect;
	logic [ADDR_W-1:0] redirect_pc;
	logic [ADDR_W-1:0] inst;
	logic [ADDR_W-1:0] inst_pc;
	logic              inst_valid;
	logic              inst_ready;
	logic              mem_req;
	logic [ADDR_W-1:0] mem_addr;
	logic              mem_rvalid;
	logic [ADDR_W-1:0] mem_rdata;

	logic [31:0]       mem_words [0:255];
	logic              mem_busy;
	logic [2:0]        mem_delay;
	logic [ADDR_W-1:0] req_addr;
	int                seed;

	// Model of the cache contents and of the expected fetch path
	logic [NUM_SETS-1:0] model_valid;
	logic [TAG_W-1:0]    model_tag [NUM_SETS];
	logic [1:0]          refill_count;
	logic [ADDR_W-1:0]   refill_base;
	logic [ADDR_W-1:0]   exp_pc;
	int                  transfer_count;
	int                  refill_lines;
	int                  fence_count;
	int                  stall_cycles;
	int                  error_count;

	logic              transfer;
	logic [31:0]       expected_inst;
	logic              inst_line_cached;
	logic              req_line_cached;
	logic [ADDR_W-1:0] exp_line_base;
	logic [ADDR_W-1:0] expected_req_addr;

	fetch_top DUT (
		.clock       (clock),
		.reset       (reset),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.inst        (inst),
		.inst_pc     (inst_pc),
		.inst_valid  (inst_valid),
		.inst_ready  (inst_ready),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_rvalid  (mem_rvalid),
		.mem_rdata   (mem_rdata)
	);

	function automatic logic [INDEX_W-1:0] line_index(input logic [ADDR_W-1:0] addr);
		return addr[OFFSET_W+INDEX_W-1:OFFSET_W];
	endfunction

	function automatic logic [TAG_W-1:0] line_tag(input logic [ADDR_W-1:0] addr);
		return addr[ADDR_W-1:OFFSET_W+INDEX_W];
	endfunction

	// misc_mem opcode with funct3 001
	function automatic logic is_fence_i(input logic [31:0] word);
		return (word[6:0] == 7'b0001111) && (word[14:12] == 3'b001);
	endfunction

	assign transfer          = inst_valid && inst_ready;
	assign expected_inst     = mem_words[inst_pc[9:2]];
	assign inst_line_cached  = model_valid[line_index(inst_pc)]
		&& (model_tag[line_index(inst_pc)] == line_tag(inst_pc));
	assign req_line_cached   = model_valid[line_index(mem_addr)]
		&& (model_tag[line_index(mem_addr)] == line_tag(mem_addr));
	// A refill starts at the line of the address being fetched
	assign exp_line_base     = exp_pc & ~ADDR_W'(WORDS_PER_LINE * 4 - 1);
	assign expected_req_addr = refill_base + ADDR_W'({refill_count, 2'b00});

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Backing memory answers one request at a time after 1 to 4 cycles
	// and decode back-pressure draws from the same random stream
	always @(posedge clock) begin
		mem_rvalid <= 1'b0;
		if (reset) begin
			mem_busy   <= 1'b0;
			inst_ready <= 1'b0;
		end else begin
			inst_ready <= (($random(seed) & 3) != 0);
			if (mem_req) begin
				mem_busy  <= 1'b1;
				mem_delay <= 3'(($unsigned($random(seed)) % 4) + 1);
				req_addr  <= mem_addr;
			end else if (mem_busy) begin
				if (mem_delay == 3'd1) begin
					mem_rvalid <= 1'b1;
					mem_rdata  <= mem_words[req_addr[9:2]];
					mem_busy   <= 1'b0;
				end else begin
					mem_delay <= mem_delay - 3'd1;
				end
			end
		end
	end

	always @(posedge clock) begin
		if (reset) begin
			model_valid  <= '0;
			refill_count <= '0;
			exp_pc       <= START_PC;
		end else begin
			if (redirect) begin
				exp_pc <= redirect_pc;
			end else if (transfer) begin
				exp_pc <= exp_pc + 32'd4;
			end
			if (transfer) begin
				transfer_count <= transfer_count + 1;
				if (is_fence_i(inst)) begin
					model_valid <= '0;
					fence_count <= fence_count + 1;
				end
			end
			if (inst_valid && !inst_ready) begin
				stall_cycles <= stall_cycles + 1;
			end
			if (mem_req) begin
				if (refill_count == 2'd0) begin
					refill_base <= exp_line_base;
				end
				refill_count <= refill_count + 2'd1;
				// The line counts as cached once all four words are requested
				if (refill_count == 2'd3) begin
					model_valid[line_index(mem_addr)] <= 1'b1;
					model_tag[line_index(mem_addr)]   <= line_tag(mem_addr);
					refill_lines <= refill_lines + 1;
				end
			end
		end
	end

	order_check: assert property (@(posedge clock) disable iff (reset)
		transfer |-> inst_pc == exp_pc)
	else begin
		error_count++;
		$display("FAIL %0t: inst_pc %h, expected %h", $time, inst_pc, exp_pc);
	end

	data_check: assert property (@(posedge clock) disable iff (reset)
		transfer |-> inst == expected_inst)
	else begin
		error_count++;
		$display("FAIL %0t: inst %h at %h, expected %h", $time, inst, inst_pc, expected_inst);
	end

	refilled_check: assert property (@(posedge clock) disable iff (reset)
		transfer |-> inst_line_cached)
	else begin
		error_count++;
		$display("FAIL %0t: transfer from %h without a refill of its line", $time, inst_pc);
	end

	aligned_check: assert property (@(posedge clock) disable iff (reset)
		mem_req |-> mem_addr[1:0] == 2'b00)
	else begin
		error_count++;
		$display("FAIL %0t: mem_addr %h not word aligned", $time, mem_addr);
	end

	first_word_check: assert property (@(posedge clock) disable iff (reset)
		mem_req && refill_count == 2'd0 |-> mem_addr == exp_line_base && !req_line_cached)
	else begin
		error_count++;
		$display("FAIL %0t: refill start at %h, expected missing line base %h",
			$time, mem_addr, exp_line_base);
	end

	next_word_check: assert property (@(posedge clock) disable iff (reset)
		mem_req && refill_count != 2'd0 |-> mem_addr == expected_req_addr)
	else begin
		error_count++;
		$display("FAIL %0t: mem_addr %h, expected %h", $time, mem_addr, expected_req_addr);
	end

	single_request_check: assert property (@(posedge clock) disable iff (reset)
		mem_req |-> !mem_busy)
	else begin
		error_count++;
		$display("FAIL %0t: mem_req while a request is outstanding", $time);
	end

	stall_stable_check: assert property (@(posedge clock) disable iff (reset)
		inst_valid && !inst_ready && !redirect |=>
			inst_valid && $stable(inst) && $stable(inst_pc))
	else begin
		error_count++;
		$display("FAIL %0t: held instruction changed under back-pressure", $time);
	end

	stall_no_req_check: assert property (@(posedge clock) disable iff (reset)
		inst_valid && !inst_ready |-> !mem_req)
	else begin
		error_count++;
		$display("FAIL %0t: mem_req while an instruction is held", $time);
	end

	task automatic wait_transfers(input int count);
		int target;
		target = transfer_count + count;
		while (transfer_count < target) begin
			@(posedge clock);
		end
	endtask

	task automatic pulse_redirect(input logic [ADDR_W-1:0] addr);
		@(posedge clock);
		redirect    <= 1'b1;
		redirect_pc <= addr;
		@(posedge clock);
		redirect    <= 1'b0;
	endtask

	initial begin
		seed           = 32'hb161_30d9;
		reset          = 1'b1;
		redirect       = 1'b0;
		redirect_pc    = '0;
		inst_ready     = 1'b0;
		mem_rvalid     = 1'b0;
		mem_rdata      = '0;
		transfer_count = 0;
		refill_lines   = 0;
		fence_count    = 0;
		stall_cycles   = 0;
		error_count    = 0;
		for (int i = 0; i < 256; i++) begin
			mem_words[i] = 32'(i * 4) + WORD_OFFSET;
		end
		mem_words[FENCE_PC[9:2]] = FENCE_WORD;

		repeat (4) @(posedge clock);
		reset <= 1'b0;

		wait_transfers(8);
		// Same set as line 0x00 with a different tag
		pulse_redirect(32'h0000_0040);
		wait_transfers(4);
		pulse_redirect(32'h0000_0000);
		wait_transfers(4);
		// Runs across the fence.i word so the rest of its line must refill
		pulse_redirect(32'h0000_0020);
		wait_transfers(6);
		pulse_redirect(32'h0000_0100);
		while (!mem_req) begin
			@(posedge clock);
		end
		repeat (2) @(posedge clock);
		pulse_redirect(32'h0000_0180);
		wait_transfers(3);

		if (fence_count == 0) begin
			$display("The fence.i word was never transferred");
			error_count++;
		end
		if (stall_cycles == 0) begin
			$display("No back-pressure cycle was seen");
			error_count++;
		end
		$display("Done: %0d transfers, %0d line refills, %0d stall cycles, %0d errors",
			transfer_count, refill_lines, stall_cycles, error_count);
		if (error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("The run timed out after %0d ns without finishing its tests", TIMEOUT_NS);
		$display("TB FAILED");
		$finish;
	end

endmodule
